// ==== hdl/spam_pkg.sv ====
package spam_pkg;

	localparam int SPAM_DID_W  = 4;	// Device id
	localparam int SPAM_ADDR_W = 8;	// Register within a device
	localparam int SPAM_DATA_W = 32;

	localparam logic [SPAM_DID_W-1:0] DID_CONSOLE = 4'd0;
	localparam logic [SPAM_DID_W-1:0] DID_LEDS    = 4'd1;
	localparam logic [SPAM_DID_W-1:0] DID_TIMER   = 4'd2;

	localparam logic [SPAM_ADDR_W-1:0] REG_DATA   = 8'd0;
	localparam logic [SPAM_ADDR_W-1:0] REG_STATUS = 8'd1;

	localparam int LED_SW_W = 4;	// Software driven LEDs

	// Master to devices, valid for one cycle per request
	typedef struct packed {
		logic                   valid;
		logic                   r_nw;	// 1 read, 0 write
		logic [SPAM_DID_W-1:0]  did;
		logic [SPAM_ADDR_W-1:0] addr;
		logic [SPAM_DATA_W-1:0] data;	// Write data
	} spam_req_t;

	// Device to master, merged by OR at the top level
	typedef struct packed {
		logic                   ack;
		logic [SPAM_DATA_W-1:0] data;	// Zero unless ack
	} spam_rsp_t;

	typedef struct packed {
		logic [LED_SW_W-1:0] sw;
		logic                flash;	// Recent read on the bus
		logic                triggered;	// Any read since reset
	} led_state_t;

endpackage

// ==== hdl/reset_seq.sv ====
`timescale 1ns/10ps

module reset_seq #(
	parameter int RST_STRETCH = 16
) (
	input  logic cclk,
	input  logic cclk_rst_cause_b,
	output logic cclk_rst_b
);

	logic [RST_STRETCH-1:0] seq;	// Fills with ones after release

	always_ff @(posedge cclk or negedge cclk_rst_cause_b) begin
		if (!cclk_rst_cause_b) begin
			seq <= '0;	// Assert at once
		end else begin
			seq <= {seq[RST_STRETCH-2:0], 1'b1};
		end
	end

	assign cclk_rst_b = seq[RST_STRETCH-1];

	// Release only after the cause has stayed high for the whole stretch
	a_release_after_stretch: assert property (
		@(posedge cclk) $rose(cclk_rst_b) |->
			cclk_rst_cause_b && $past(cclk_rst_cause_b, RST_STRETCH - 1)
	) else $error("reset_seq: release without a full stretch");

endmodule

// ==== hdl/uart_tx.sv ====
`timescale 1ns/10ps

module uart_tx #(
	parameter int CLKS_PER_BIT = 434
) (
	input  logic       cclk,
	input  logic       cclk_rst_b,
	input  logic       byte_valid,
	input  logic [7:0] byte_data,
	output logic       byte_ready,
	output logic       serial_tx
);

	localparam int CNT_W      = $clog2(CLKS_PER_BIT);
	localparam int FRAME_BITS = 10;	// Start, 8 data, stop

	logic             busy;
	logic [CNT_W-1:0] bit_cnt;	// Cycles within the current bit
	logic [3:0]       bit_idx;
	logic [9:0]       shifter;	// LSB is on the line
	logic             bit_end;

	assign bit_end    = (bit_cnt == CNT_W'(CLKS_PER_BIT - 1));
	assign byte_ready = !busy;
	assign serial_tx  = shifter[0];

	always_ff @(posedge cclk or negedge cclk_rst_b) begin
		if (!cclk_rst_b) begin
			busy    <= 1'b0;
			bit_cnt <= '0;
			bit_idx <= '0;
			shifter <= '1;	// Line idles high
		end else if (!busy) begin
			if (byte_valid) begin
				busy    <= 1'b1;
				bit_cnt <= '0;
				bit_idx <= '0;
				shifter <= {1'b1, byte_data, 1'b0};
			end
		end else if (bit_end) begin
			bit_cnt <= '0;
			shifter <= {1'b1, shifter[9:1]};	// Ones fill in behind the stop bit
			if (bit_idx == 4'(FRAME_BITS - 1)) begin
				busy <= 1'b0;	// Stop bit done
			end else begin
				bit_idx <= bit_idx + 1'b1;
			end
		end else begin
			bit_cnt <= bit_cnt + 1'b1;
		end
	end

endmodule

// ==== hdl/spam_timer.sv ====
`timescale 1ns/10ps

module spam_timer
	import spam_pkg::*;
(
	input  logic      cclk,
	input  logic      cclk_rst_b,
	input  spam_req_t req,
	output spam_rsp_t rsp
);

	logic [SPAM_DATA_W-1:0] count;
	logic                   sel;	// Request for this device
	logic                   hit_data;

	assign sel      = req.valid && (req.did == DID_TIMER);
	assign hit_data = sel && (req.addr == REG_DATA);

	always_ff @(posedge cclk or negedge cclk_rst_b) begin
		if (!cclk_rst_b) begin
			count <= '0;
		end else if (hit_data && !req.r_nw) begin
			count <= req.data;	// Software load
		end else begin
			count <= count + 1'b1;
		end
	end

	// Respond one cycle after the request
	always_ff @(posedge cclk or negedge cclk_rst_b) begin
		if (!cclk_rst_b) begin
			rsp <= '0;
		end else begin
			rsp.ack <= sel;
			if (hit_data && req.r_nw) begin
				rsp.data <= count;	// Count at the request edge
			end else begin
				rsp.data <= '0;
			end
		end
	end

	// One request gives one single-cycle ack
	a_ack_single: assert property (
		@(posedge cclk) disable iff (!cclk_rst_b) rsp.ack |=> !rsp.ack
	) else $error("spam_timer: ack held for two cycles");

endmodule

// ==== hdl/spam_leds.sv ====
`timescale 1ns/10ps

module spam_leds
	import spam_pkg::*;
#(
	parameter int FLASH_CYCLES = 5000000
) (
	input  logic       cclk,
	input  logic       cclk_rst_b,
	input  spam_req_t  req,
	output spam_rsp_t  rsp,
	output led_state_t leds
);

	localparam int CNT_W = $clog2(FLASH_CYCLES + 1);

	logic [LED_SW_W-1:0] sw_q;
	logic [CNT_W-1:0]    flash_cnt;	// Zero when idle
	logic                triggered_q;
	logic                sel;
	logic                hit_data;
	logic                bus_read;	// Read to any device

	assign sel      = req.valid && (req.did == DID_LEDS);
	assign hit_data = sel && (req.addr == REG_DATA);
	assign bus_read = req.valid && req.r_nw;

	always_ff @(posedge cclk or negedge cclk_rst_b) begin
		if (!cclk_rst_b) begin
			sw_q        <= '0;
			flash_cnt   <= '0;
			triggered_q <= 1'b0;
			rsp         <= '0;
		end else begin
			if (hit_data && !req.r_nw) begin
				sw_q <= req.data[LED_SW_W-1:0];
			end
			if (bus_read) begin
				flash_cnt   <= CNT_W'(1);	// Restart the flash
				triggered_q <= 1'b1;	// Sticky
			end else if (flash_cnt == CNT_W'(FLASH_CYCLES)) begin
				flash_cnt <= '0;
			end else if (flash_cnt != '0) begin
				flash_cnt <= flash_cnt + 1'b1;
			end
			rsp.ack <= sel;
			if (hit_data && req.r_nw) begin
				rsp.data <= SPAM_DATA_W'(sw_q);
			end else begin
				rsp.data <= '0;
			end
		end
	end

	assign leds.sw        = sw_q;
	assign leds.flash     = (flash_cnt != '0);
	assign leds.triggered = triggered_q;

	// Flash count stays within the flash length
	a_flash_limit: assert property (
		@(posedge cclk) disable iff (!cclk_rst_b) flash_cnt <= CNT_W'(FLASH_CYCLES)
	) else $error("spam_leds: flash counter ran past its limit");

endmodule

// ==== hdl/spam_console.sv ====
`timescale 1ns/10ps

module spam_console
	import spam_pkg::*;
#(
	parameter int CLKS_PER_BIT = 434
) (
	input  logic      cclk,
	input  logic      cclk_rst_b,
	input  spam_req_t req,
	output spam_rsp_t rsp,
	output logic      serial_tx
);

	logic       buf_full;	// Byte waiting for the shifter
	logic [7:0] buf_data;
	logic       wr_pending;	// Write held off, ack not yet given
	logic [7:0] wr_byte;
	logic       byte_ready;
	logic       take;	// Shifter takes the buffer this cycle
	logic       sel;
	logic       new_wr;
	logic       accept_now;
	logic       accept_late;
	logic       tx_busy;

	assign sel         = req.valid && (req.did == DID_CONSOLE);
	assign new_wr      = sel && !req.r_nw && (req.addr == REG_DATA);
	assign take        = buf_full && byte_ready;
	assign accept_now  = new_wr && (!buf_full || take);
	assign accept_late = wr_pending && (!buf_full || take);
	assign tx_busy     = buf_full || !byte_ready;

	always_ff @(posedge cclk or negedge cclk_rst_b) begin
		if (!cclk_rst_b) begin
			buf_full   <= 1'b0;
			wr_pending <= 1'b0;
			rsp        <= '0;
		end else begin
			if (accept_now || accept_late) begin
				buf_full <= 1'b1;
			end else if (take) begin
				buf_full <= 1'b0;
			end
			if (new_wr && !accept_now) begin
				wr_pending <= 1'b1;	// Back-pressure
			end else if (accept_late) begin
				wr_pending <= 1'b0;
			end
			// Reads and stray writes ack at once, data writes once buffered
			rsp.ack <= (sel && !new_wr) || accept_now || accept_late;
			if (sel && req.r_nw && (req.addr == REG_STATUS)) begin
				rsp.data <= {{(SPAM_DATA_W-1){1'b0}}, tx_busy};
			end else begin
				rsp.data <= '0;
			end
		end
	end

	always_ff @(posedge cclk) begin
		if (new_wr) begin
			wr_byte <= req.data[7:0];
		end
		if (accept_now) begin
			buf_data <= req.data[7:0];
		end else if (accept_late) begin
			buf_data <= wr_byte;
		end
	end

	uart_tx #(
		.CLKS_PER_BIT(CLKS_PER_BIT)
	) uart_tx_i (
		.cclk      (cclk),
		.cclk_rst_b(cclk_rst_b),
		.byte_valid(buf_full),
		.byte_data (buf_data),
		.byte_ready(byte_ready),
		.serial_tx (serial_tx)
	);

	// The master waits for ack before its next request
	a_no_req_while_pending: assert property (
		@(posedge cclk) disable iff (!cclk_rst_b) wr_pending |-> !req.valid
	) else $error("spam_console: request issued during a pending write");

endmodule

// ==== hdl/spam_system.sv ====
`timescale 1ns/10ps

module spam_system
	import spam_pkg::*;
#(
	parameter int RST_STRETCH  = 16,
	parameter int FLASH_CYCLES = 5000000,	// About 100 ms at 50 MHz
	parameter int CLKS_PER_BIT = 434	// 115200 baud at 50 MHz
) (
	input  logic       cclk,
	input  logic       cclk_rst_cause_b,
	input  spam_req_t  host_req,
	output spam_rsp_t  host_rsp,
	output led_state_t leds,
	output logic       serial_tx
);

	logic      cclk_rst_b;	// Stretched release
	spam_rsp_t timer_rsp;
	spam_rsp_t leds_rsp;
	spam_rsp_t console_rsp;

	reset_seq #(
		.RST_STRETCH(RST_STRETCH)
	) reset_seq_i (
		.cclk            (cclk),
		.cclk_rst_cause_b(cclk_rst_cause_b),
		.cclk_rst_b      (cclk_rst_b)
	);

	spam_timer timer_i (
		.cclk      (cclk),
		.cclk_rst_b(cclk_rst_b),
		.req       (host_req),
		.rsp       (timer_rsp)
	);

	spam_leds #(
		.FLASH_CYCLES(FLASH_CYCLES)
	) leds_i (
		.cclk      (cclk),
		.cclk_rst_b(cclk_rst_b),
		.req       (host_req),
		.rsp       (leds_rsp),
		.leds      (leds)
	);

	spam_console #(
		.CLKS_PER_BIT(CLKS_PER_BIT)
	) console_i (
		.cclk      (cclk),
		.cclk_rst_b(cclk_rst_b),
		.req       (host_req),
		.rsp       (console_rsp),
		.serial_tx (serial_tx)
	);

	// Idle devices drive zeros, so a plain OR is the response mux
	assign host_rsp = timer_rsp | leds_rsp | console_rsp;

endmodule

// ==== dv/tb_clock.sv ====
`timescale 1ns/10ps

module tb_clock #(
	parameter int HALF_PERIOD = 50,	// 100 ns clock
	parameter int RST_CYCLES  = 4
) (
	output logic cclk,
	output logic cclk_rst_cause_b
);

	initial begin
		cclk = 1'b0;
		forever begin
			#(HALF_PERIOD) cclk = ~cclk;
		end
	end

	// Release just after an edge, like every other testbench input
	initial begin
		cclk_rst_cause_b = 1'b0;
		repeat (RST_CYCLES) @(posedge cclk);
		#1 cclk_rst_cause_b = 1'b1;
	end

endmodule

// ==== dv/tb_spam_system.sv ====
`timescale 1ns/10ps

module tb_spam_system
	import spam_pkg::*;
();

	localparam int FLASH_CYCLES   = 20;
	localparam int CLKS_PER_BIT   = 8;
	localparam int NUM_STEPS      = 20;
	localparam int START_DELAY    = 20;	// Cycles after the cause is released
	localparam int TIMEOUT_CYCLES = NUM_STEPS * 12 * CLKS_PER_BIT + 200;
	localparam int unsigned SEED  = 32'h7c34c45a;

	localparam logic [2:0] OP_REQ    = 3'd0;	// Bus request
	localparam logic [2:0] OP_IDLE   = 3'd1;	// Wait data cycles
	localparam logic [2:0] OP_LEDS   = 3'd2;	// Compare the LED outputs
	localparam logic [2:0] OP_LINE   = 3'd3;	// Compare serial_tx
	localparam logic [2:0] OP_RXWAIT = 3'd4;	// Wait for data decoded bytes

	localparam logic [1:0] CHK_NONE  = 2'd0;
	localparam logic [1:0] CHK_EQ    = 2'd1;	// Masked compare
	localparam logic [1:0] CHK_RANGE = 2'd2;	// expected up to expected + mask
	localparam logic [1:0] CHK_INC   = 2'd3;	// Above the previous read

	typedef struct packed {
		logic [2:0]             op;
		logic                   r_nw;
		logic [SPAM_DID_W-1:0]  did;
		logic [SPAM_ADDR_W-1:0] addr;
		logic [SPAM_DATA_W-1:0] data;
		logic [1:0]             chk;
		logic [SPAM_DATA_W-1:0] expected;
		logic [SPAM_DATA_W-1:0] mask;
	} step_t;

	logic       cclk;
	logic       cclk_rst_cause_b;
	spam_req_t  host_req;
	spam_rsp_t  host_rsp;
	led_state_t leds;
	logic       serial_tx;

	step_t      steps [NUM_STEPS];
	int         n_steps     = 0;
	int         cycle_count = 0;
	logic [7:0] rx_bytes [$];	// Decoded from the serial line
	logic [7:0] tx_expect [$];	// Low bytes of the console writes

	tb_clock clock_i (
		.cclk            (cclk),
		.cclk_rst_cause_b(cclk_rst_cause_b)
	);

	spam_system #(
		.FLASH_CYCLES(FLASH_CYCLES),
		.CLKS_PER_BIT(CLKS_PER_BIT)
	) dut_i (
		.cclk            (cclk),
		.cclk_rst_cause_b(cclk_rst_cause_b),
		.host_req        (host_req),
		.host_rsp        (host_rsp),
		.leds            (leds),
		.serial_tx       (serial_tx)
	);

	task automatic report_error(input string msg);
		$display("[ERROR] %0d ns %s", $time, msg);
		$display("TESTS FAILED");
		$fatal(1);
	endtask

	task automatic add_step(input logic [2:0] op, input logic r_nw,
			input logic [SPAM_DID_W-1:0] did, input logic [SPAM_ADDR_W-1:0] addr,
			input logic [SPAM_DATA_W-1:0] data, input logic [1:0] chk,
			input logic [SPAM_DATA_W-1:0] expected, input logic [SPAM_DATA_W-1:0] mask);
		steps[n_steps] = '{op, r_nw, did, addr, data, chk, expected, mask};
		n_steps++;
	endtask

	// One request, held for one cycle, then wait for its single-cycle ack
	task automatic run_request(input step_t s, output logic [SPAM_DATA_W-1:0] rd_data,
			output int wait_cycles);
		@(posedge cclk);
		#1;
		assert (host_rsp.ack === 1'b0) else report_error("ack high with no request");
		host_req.valid = 1'b1;
		host_req.r_nw  = s.r_nw;
		host_req.did   = s.did;
		host_req.addr  = s.addr;
		host_req.data  = s.r_nw ? '0 : s.data;
		@(posedge cclk);
		#1;
		host_req = '0;
		wait_cycles = 1;
		while (host_rsp.ack !== 1'b1) begin
			@(posedge cclk);
			#1;
			wait_cycles++;
		end
		rd_data = host_rsp.data;
		@(posedge cclk);
		#1;
		assert (host_rsp.ack === 1'b0) else report_error("ack lasted more than one cycle");
	endtask

	task automatic check_read(input int idx, input step_t s,
			input logic [SPAM_DATA_W-1:0] rd_data, input logic [SPAM_DATA_W-1:0] last_rd);
		case (s.chk)
			CHK_EQ: assert ((rd_data & s.mask) === (s.expected & s.mask)) else
				report_error($sformatf("step %0d read 0x%08h, expected 0x%08h",
					idx, rd_data, s.expected));
			CHK_RANGE: assert ((rd_data - s.expected) <= s.mask) else
				report_error($sformatf("step %0d read 0x%08h, expected 0x%08h to +%0d",
					idx, rd_data, s.expected, s.mask));
			CHK_INC: assert (rd_data > last_rd) else
				report_error($sformatf("step %0d read 0x%08h, not above 0x%08h",
					idx, rd_data, last_rd));
			default: ;
		endcase
	endtask

	// Serial decoder, sampled on the falling edge in mid-bit
	initial begin
		logic [7:0] rx_byte;
		forever begin
			@(negedge cclk);
			if (cclk_rst_cause_b && serial_tx === 1'b0) begin
				repeat (CLKS_PER_BIT / 2) @(negedge cclk);
				assert (serial_tx === 1'b0) else report_error("start bit too short");
				for (int b = 0; b < 8; b++) begin
					repeat (CLKS_PER_BIT) @(negedge cclk);
					rx_byte[b] = serial_tx;	// LSB first
				end
				repeat (CLKS_PER_BIT) @(negedge cclk);
				assert (serial_tx === 1'b1) else report_error("stop bit is low");
				rx_bytes.push_back(rx_byte);
			end
		end
	end

	always @(posedge cclk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TESTS FAILED");
			$fatal(1);
		end
	end

	initial begin
		step_t                  s;
		logic [SPAM_DATA_W-1:0] rd_data;
		logic [SPAM_DATA_W-1:0] last_rd;
		logic [SPAM_DATA_W-1:0] led_val;
		logic [SPAM_DATA_W-1:0] timer_val;
		logic [SPAM_DATA_W-1:0] tx_word [3];
		logic [5:0]             leds_bits;
		int unsigned            seed_ret;
		int                     wait_cycles;
		logic                   held;

		host_req = '0;
		last_rd  = '0;
		seed_ret = $urandom(SEED);
		led_val   = $urandom;
		timer_val = $urandom & 32'h7fff_ffff;	// Keep clear of wrap
		for (int k = 0; k < 3; k++) begin
			tx_word[k] = $urandom;
		end

		add_step(OP_LEDS, 1'b0, '0, '0, '0, CHK_NONE, '0, 32'h3f);
		add_step(OP_LINE, 1'b0, '0, '0, '0, CHK_NONE, 32'd1, 32'd1);
		add_step(OP_REQ, 1'b0, DID_LEDS, REG_DATA, led_val, CHK_NONE, '0, '0);
		add_step(OP_LEDS, 1'b0, '0, '0, '0, CHK_NONE, {26'd0, led_val[3:0], 2'b00}, 32'h3f);
		add_step(OP_REQ, 1'b1, DID_LEDS, REG_DATA, '0, CHK_EQ, {28'd0, led_val[3:0]}, '1);
		add_step(OP_LEDS, 1'b0, '0, '0, '0, CHK_NONE, {26'd0, led_val[3:0], 2'b11}, 32'h3f);
		add_step(OP_IDLE, 1'b0, '0, '0, 32'd40, CHK_NONE, '0, '0);
		add_step(OP_LEDS, 1'b0, '0, '0, '0, CHK_NONE, {26'd0, led_val[3:0], 2'b01}, 32'h3f);
		add_step(OP_REQ, 1'b0, DID_TIMER, REG_DATA, timer_val, CHK_NONE, '0, '0);
		add_step(OP_REQ, 1'b1, DID_TIMER, REG_DATA, '0, CHK_RANGE, timer_val, 32'd8);
		add_step(OP_REQ, 1'b1, DID_TIMER, REG_DATA, '0, CHK_INC, '0, '0);
		add_step(OP_REQ, 1'b1, DID_TIMER, REG_DATA, '0, CHK_INC, '0, '0);
		add_step(OP_REQ, 1'b0, DID_CONSOLE, REG_DATA, tx_word[0], CHK_NONE, '0, '0);
		add_step(OP_REQ, 1'b0, DID_CONSOLE, REG_DATA, tx_word[1], CHK_NONE, '0, '0);
		add_step(OP_REQ, 1'b0, DID_CONSOLE, REG_DATA, tx_word[2], CHK_NONE, '0, '0);
		add_step(OP_REQ, 1'b1, DID_CONSOLE, REG_STATUS, '0, CHK_EQ, 32'd1, '1);	// Busy
		add_step(OP_RXWAIT, 1'b0, '0, '0, 32'd3, CHK_NONE, '0, '0);
		add_step(OP_IDLE, 1'b0, '0, '0, 32'(CLKS_PER_BIT), CHK_NONE, '0, '0);	// Rest of stop bit
		add_step(OP_REQ, 1'b1, DID_CONSOLE, REG_STATUS, '0, CHK_EQ, 32'd0, '1);
		add_step(OP_LINE, 1'b0, '0, '0, '0, CHK_NONE, 32'd1, 32'd1);

		@(posedge cclk_rst_cause_b);
		repeat (START_DELAY) @(posedge cclk);
		#1;

		for (int i = 0; i < NUM_STEPS; i++) begin
			s = steps[i];
			case (s.op)
				OP_REQ: begin
					run_request(s, rd_data, wait_cycles);
					// First byte goes to the shifter, second to the buffer, third is held
					held = (s.did == DID_CONSOLE) && (s.addr == REG_DATA) && !s.r_nw
						&& (tx_expect.size() == 2);
					assert (held ? (wait_cycles > 1) : (wait_cycles == 1)) else
						report_error($sformatf("step %0d ack after %0d cycles", i, wait_cycles));
					if (s.r_nw) begin
						check_read(i, s, rd_data, last_rd);
						last_rd = rd_data;
					end else begin
						assert (rd_data === '0) else
							report_error($sformatf("step %0d write returned 0x%08h", i, rd_data));
						if (s.did == DID_CONSOLE && s.addr == REG_DATA) begin
							tx_expect.push_back(s.data[7:0]);
						end
					end
				end
				OP_IDLE: begin
					repeat (s.data) @(posedge cclk);
					#1;
				end
				OP_LEDS: begin
					leds_bits = leds;
					assert ((leds_bits & s.mask[5:0]) === (s.expected[5:0] & s.mask[5:0])) else
						report_error($sformatf("step %0d leds 0x%02h, expected 0x%02h",
							i, leds_bits, s.expected[5:0]));
				end
				OP_LINE: assert (serial_tx === s.expected[0]) else
					report_error($sformatf("step %0d serial_tx %b, expected %b",
						i, serial_tx, s.expected[0]));
				OP_RXWAIT: begin
					while (rx_bytes.size() < int'(s.data)) begin
						@(posedge cclk);
						#1;
					end
					for (int k = 0; k < rx_bytes.size(); k++) begin
						assert (rx_bytes[k] === tx_expect[k]) else
							report_error($sformatf("serial byte %0d is 0x%02h, expected 0x%02h",
								k, rx_bytes[k], tx_expect[k]));
					end
				end
				default: report_error($sformatf("step %0d has an unknown operation", i));
			endcase
		end

		$display("TESTS PASSED");
		$finish;
	end

endmodule

// ==== flist.f ====
hdl/spam_pkg.sv
hdl/reset_seq.sv
hdl/uart_tx.sv
hdl/spam_timer.sv
hdl/spam_leds.sv
hdl/spam_console.sv
hdl/spam_system.sv
dv/tb_clock.sv
dv/tb_spam_system.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the spam_system testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 \
	--top-module tb_spam_system \
	-f flist.f \
	-o sim_spam_system

# The simulator exits non-zero on a failure, so let tee keep the pipe status
./obj_dir/sim_spam_system | tee sim.log

if grep -q "TESTS FAILED" sim.log; then
	echo "Simulation reported a failure, see sim.log"
	exit 1
fi
echo "Simulation finished without failures"
